/* project.f */
common/pcie_wr_pkg.sv
hdl/fifo_rvho.sv
write_buffer/outbound_write_buffer.sv
hdl/write_cmd_splitter.sv
hdl/tlp_write_framer.sv
hdl/pcie_outbound_write.sv
verification/pcie_outbound_write_assertions.sv
verification/pcie_outbound_write_tb.sv

/* verification/pcie_outbound_write_tb.sv */
`timescale 1ns/10ps

module pcie_outbound_write_tb import pcie_wr_pkg::*; ();

    localparam int ADDR           = 32;
    localparam int LEN            = 4;
    localparam int MOT            = 16;
    localparam int BUFA           = LEN + 1;
    localparam int MAX_PAYLOAD    = 8;
    localparam int ROWS           = 10;
    localparam int CYCLES_PER_ROW = 400;

    logic            clk;
    logic            rst;
    logic            aw_ready;
    logic            aw_valid;
    logic [ADDR-1:0] aw_addr;
    logic [LEN-1:0]  aw_len;
    logic            w_ready;
    logic            w_valid;
    logic            w_last;
    logic [3:0]      w_strb;
    logic [31:0]     w_data;
    logic            b_ready;
    logic            b_valid;
    logic [1:0]      b_resp;
    logic            tlp_ready;
    logic            tlp_valid;
    logic [31:0]     tlp_data;
    logic            tlp_sof;
    logic            tlp_eof;
    logic            wr_busy;
    logic            wr_disable;
    logic            wr_flush;

    // Stimulus table, one row per burst
    logic [29:0]     row_addr [ROWS];
    logic [LEN-1:0]  row_len [ROWS];
    logic [3:0]      row_first [ROWS];
    logic [3:0]      row_last [ROWS];
    int              row_hold [ROWS];
    logic            row_flush [ROWS];
    logic            row_dis [ROWS];
    logic [1:0]      row_resp [ROWS];
    int              row_cnt;

    logic [31:0]     burst_data [2**LEN];
    logic [3:0]      burst_strb [2**LEN];
    // Expected TLP words as sof, eof, data
    logic [33:0]     exp_tlp [$];
    logic [1:0]      exp_b [$];
    logic [33:0]     tlp_exp_word;
    logic [1:0]      b_exp_resp;
    logic [31:0]     lfsr;
    int              errors;
    int              checks;
    int              stall_left;
    logic            hold_tlp;
    logic            saw_aw_stall;

    pcie_outbound_write #(
        .ADDR        (ADDR),
        .LEN         (LEN),
        .MOT         (MOT),
        .BUFA        (BUFA),
        .MAX_PAYLOAD (MAX_PAYLOAD)
    ) pcie_outbound_write_i (
        .clk        (clk),
        .rst        (rst),
        .aw_ready   (aw_ready),
        .aw_valid   (aw_valid),
        .aw_addr    (aw_addr),
        .aw_len     (aw_len),
        .w_ready    (w_ready),
        .w_valid    (w_valid),
        .w_last     (w_last),
        .w_strb     (w_strb),
        .w_data     (w_data),
        .b_ready    (b_ready),
        .b_valid    (b_valid),
        .b_resp     (b_resp),
        .tlp_ready  (tlp_ready),
        .tlp_valid  (tlp_valid),
        .tlp_data   (tlp_data),
        .tlp_sof    (tlp_sof),
        .tlp_eof    (tlp_eof),
        .wr_busy    (wr_busy),
        .wr_disable (wr_disable),
        .wr_flush   (wr_flush)
    );

    bind pcie_outbound_write pcie_outbound_write_assertions assertions_i (.*);

    always #2 clk = ~clk;

    task automatic add_row(input logic [29:0] addr, input logic [LEN-1:0] len,
                           input logic [3:0] first, input logic [3:0] last,
                           input int hold, input logic flush, input logic dis,
                           input logic [1:0] resp);
        row_addr[row_cnt]  = addr;
        row_len[row_cnt]   = len;
        row_first[row_cnt] = first;
        row_last[row_cnt]  = last;
        row_hold[row_cnt]  = hold;
        row_flush[row_cnt] = flush;
        row_dis[row_cnt]   = dis;
        row_resp[row_cnt]  = resp;
        row_cnt++;
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_word(output logic [31:0] word);
        for (int b = 0; b < 32; b++) begin
            word[b] = lfsr[0];
            lfsr    = lfsr_step(lfsr);
        end
    endtask

    // Split the burst at MAX_PAYLOAD boundaries and queue its TLP words
    task automatic build_expected(input int r);
        int          n;
        int          k;
        int          piece;
        logic [29:0] a;
        logic [3:0]  lbe;
        logic        eof;
        n = int'(row_len[r]) + 1;
        for (int i = 0; i < n; i++) begin
            take_word(burst_data[i]);
            burst_strb[i] = (i == 0) ? row_first[r] : ((i == n - 1) ? row_last[r] : 4'hf);
        end
        a = row_addr[r];
        k = 0;
        while (k < n) begin
            piece = MAX_PAYLOAD - int'(a % MAX_PAYLOAD);
            if (piece > n - k) begin
                piece = n - k;
            end
            lbe = (piece > 1) ? burst_strb[k + piece - 1] : 4'h0;
            exp_tlp.push_back({2'b10, 8'h00, lbe, burst_strb[k], 6'h00, 10'(piece)});
            exp_tlp.push_back({2'b00, a, 2'b00});
            for (int i = 0; i < piece; i++) begin
                eof = (i == piece - 1);
                exp_tlp.push_back({1'b0, eof, burst_data[k + i]});
            end
            a = a + 30'(piece);
            k = k + piece;
        end
        exp_b.push_back(row_resp[r]);
    endtask

    task automatic send_aw(input int r);
        @(negedge clk);
        aw_valid = 1'b1;
        aw_addr  = {row_addr[r], 2'b00};
        aw_len   = row_len[r];
        if (row_dis[r]) begin
            // Burst offered while disabled must not be taken
            repeat (20) begin
                @(posedge clk);
                checks++;
                if (aw_ready) begin
                    errors++;
                    $display("Fail at %0d ns: aw_ready high while wr_disable is set", $time);
                end
            end
            @(negedge clk);
            wr_disable = 1'b0;
        end
        do begin
            @(posedge clk);
            if (!aw_ready && !tlp_ready && !wr_disable) begin
                saw_aw_stall = 1'b1;
            end
        end while (!aw_ready);
        @(negedge clk);
        aw_valid = 1'b0;
    endtask

    task automatic send_w(input int r);
        int n;
        n = int'(row_len[r]) + 1;
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            w_valid = 1'b1;
            w_data  = burst_data[i];
            w_strb  = burst_strb[i];
            w_last  = (i == n - 1);
            do begin
                @(posedge clk);
            end while (!w_ready);
        end
        @(negedge clk);
        w_valid = 1'b0;
        w_last  = 1'b0;
    endtask

    // Wait until every expected word and response has been seen
    task automatic drain_all();
        do begin
            @(negedge clk);
        end while (exp_tlp.size() != 0 || exp_b.size() != 0);
        checks++;
        if (wr_busy) begin
            errors++;
            $display("Fail at %0d ns: wr_busy high after every response was accepted", $time);
        end
    endtask

    // TLP output back-pressure, B channel ready on every other cycle
    always @(negedge clk) begin
        if (hold_tlp || stall_left > 0) begin
            tlp_ready = 1'b0;
        end else begin
            tlp_ready = 1'b1;
        end
        if (stall_left > 0) begin
            stall_left--;
        end
        b_ready = !b_ready;
    end

    always @(posedge clk) begin
        if (!rst && tlp_valid && tlp_ready) begin
            checks++;
            if (exp_tlp.size() == 0) begin
                errors++;
                $display("Error: TLP word %h sent when none was expected", tlp_data);
            end else begin
                tlp_exp_word = exp_tlp.pop_front();
                if ({tlp_sof, tlp_eof, tlp_data} != tlp_exp_word) begin
                    errors++;
                    $display("Fail at %0d ns: TLP sof %b eof %b data %h, expected %b %b %h",
                             $time, tlp_sof, tlp_eof, tlp_data, tlp_exp_word[33],
                             tlp_exp_word[32], tlp_exp_word[31:0]);
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && b_valid && b_ready) begin
            checks++;
            if (exp_b.size() == 0) begin
                errors++;
                $display("Error: write response %b arrived when none was expected", b_resp);
            end else begin
                b_exp_resp = exp_b.pop_front();
                if (b_resp != b_exp_resp) begin
                    errors++;
                    $display("Fail at %0d ns: b_resp %b, expected %b", $time, b_resp, b_exp_resp);
                end
            end
        end
    end

    initial begin
        repeat (ROWS * CYCLES_PER_ROW) @(posedge clk);
        $display("Error: watchdog expired after %0d cycles, %0d errors so far",
                 ROWS * CYCLES_PER_ROW, errors);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        aw_valid     = 1'b0;
        aw_addr      = '0;
        aw_len       = '0;
        w_valid      = 1'b0;
        w_last       = 1'b0;
        w_strb       = '0;
        w_data       = '0;
        b_ready      = 1'b1;
        tlp_ready    = 1'b1;
        wr_disable   = 1'b0;
        wr_flush     = 1'b0;
        lfsr         = 32'd31404;
        errors       = 0;
        checks       = 0;
        stall_left   = 0;
        hold_tlp     = 1'b0;
        saw_aw_stall = 1'b0;
        row_cnt      = 0;

        //      dword addr len    first last  hold flush dis  response
        add_row(30'h040, 4'd3,  4'hf, 4'hf, 0,   0,    0,   axi_resp_okay);
        add_row(30'h045, 4'd9,  4'he, 4'h3, 0,   0,    0,   axi_resp_okay);
        add_row(30'h086, 4'd15, 4'hc, 4'h1, 0,   0,    0,   axi_resp_okay);
        add_row(30'h023, 4'd0,  4'h6, 4'h6, 0,   0,    0,   axi_resp_okay);
        add_row(30'h200, 4'd15, 4'hf, 4'hf, 150, 0,    0,   axi_resp_okay);
        add_row(30'h210, 4'd15, 4'h3, 4'hc, 0,   0,    0,   axi_resp_okay);
        add_row(30'h227, 4'd12, 4'h8, 4'h1, 0,   0,    0,   axi_resp_okay);
        add_row(30'h300, 4'd7,  4'hf, 4'hf, 0,   1,    0,   axi_resp_slverr);
        add_row(30'h400, 4'd2,  4'h7, 4'he, 0,   0,    1,   axi_resp_okay);
        add_row(30'h05d, 4'd5,  4'h8, 4'h7, 12,  0,    0,   axi_resp_okay);

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int r = 0; r < row_cnt; r++) begin
            if (row_flush[r] || row_dis[r]) begin
                drain_all();
            end
            if (row_dis[r]) begin
                wr_disable = 1'b1;
            end
            @(posedge clk);
            hold_tlp = row_flush[r];
            if (row_hold[r] > stall_left) begin
                stall_left = row_hold[r];
            end
            build_expected(r);
            send_aw(r);
            send_w(r);
            if (row_flush[r]) begin
                // Burst is answered while its data is still held back
                wr_flush = 1'b1;
                do begin
                    @(negedge clk);
                end while (exp_b.size() != 0);
                @(posedge clk);
                hold_tlp = 1'b0;
                do begin
                    @(negedge clk);
                end while (exp_tlp.size() != 0);
                wr_flush = 1'b0;
            end
        end
        drain_all();

        checks++;
        if (!saw_aw_stall) begin
            errors++;
            $display("Error: aw_ready never fell while the TLP output was stalled");
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verification/pcie_outbound_write_assertions.sv */
`timescale 1ns/10ps

module pcie_outbound_write_assertions (
    input logic clk,
    input logic rst,
    input logic aw_valid,
    input logic aw_ready,
    input logic w_valid,
    input logic w_ready,
    input logic b_valid,
    input logic b_ready,
    input logic tlp_valid,
    input logic tlp_ready,
    input logic tlp_sof,
    input logic tlp_eof,
    input logic wr_busy
);

    // A raised valid holds until its transfer
    aw_valid_held: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid)
        else $error("aw_valid dropped before its transfer");

    w_valid_held: assert property (@(posedge clk) disable iff (rst)
        w_valid && !w_ready |=> w_valid)
        else $error("w_valid dropped before its transfer");

    b_valid_held: assert property (@(posedge clk) disable iff (rst)
        b_valid && !b_ready |=> b_valid)
        else $error("b_valid dropped before its transfer");

    tlp_valid_held: assert property (@(posedge clk) disable iff (rst)
        tlp_valid && !tlp_ready |=> tlp_valid)
        else $error("tlp_valid dropped before its transfer");

    // A response only exists for an outstanding burst
    b_valid_busy: assert property (@(posedge clk) disable iff (rst)
        b_valid |-> wr_busy)
        else $error("b_valid high while wr_busy is low");

    sof_eof_apart: assert property (@(posedge clk) disable iff (rst)
        tlp_valid |-> !(tlp_sof && tlp_eof))
        else $error("tlp_sof and tlp_eof in the same cycle");

endmodule

/* hdl/pcie_outbound_write.sv */
`timescale 1ns/10ps

module pcie_outbound_write import pcie_wr_pkg::*; #(
    parameter int ADDR        = 32,
    parameter int LEN         = 4,
    parameter int MOT         = 16,
    parameter int BUFA        = LEN + 1,
    parameter int MAX_PAYLOAD = 8
) (
    input  logic            clk,
    input  logic            rst,
    output logic            aw_ready,
    input  logic            aw_valid,
    input  logic [ADDR-1:0] aw_addr,
    input  logic [LEN-1:0]  aw_len,
    output logic            w_ready,
    input  logic            w_valid,
    input  logic            w_last,
    input  logic [3:0]      w_strb,
    input  logic [31:0]     w_data,
    input  logic            b_ready,
    output logic            b_valid,
    output logic [1:0]      b_resp,
    input  logic            tlp_ready,
    output logic            tlp_valid,
    output logic [31:0]     tlp_data,
    output logic            tlp_sof,
    output logic            tlp_eof,
    output logic            wr_busy,
    input  logic            wr_disable,
    input  logic            wr_flush
);

    logic                 cmd_aw_ready;
    logic                 cmd_aw_valid;
    logic [ADDR-1:2]      cmd_aw_addr;
    logic [LEN-1:0]       cmd_aw_len;
    logic                 cmd_w_ready;
    logic                 cmd_w_valid;
    logic [3:0]           cmd_w_strb;
    logic                 req_ready;
    logic                 req_valid;
    logic [ADDR-1:2]      req_addr;
    logic [tlp_len_w-1:0] req_len;
    logic [tlp_be_w-1:0]  req_first_be;
    logic [tlp_be_w-1:0]  req_last_be;
    logic                 tlp_d_ready;
    logic                 tlp_d_valid;
    logic [31:0]          tlp_d_data;
    logic                 tlp_d_axi_last;
    logic                 tlp_d_axi_ack;

    outbound_write_buffer #(
        .ADDR (ADDR),
        .LEN  (LEN),
        .MOT  (MOT),
        .BUFA (BUFA)
    ) buffer_i (
        .clk            (clk),
        .rst            (rst),
        .aw_ready       (aw_ready),
        .aw_valid       (aw_valid),
        .aw_addr        (aw_addr),
        .aw_len         (aw_len),
        .w_ready        (w_ready),
        .w_valid        (w_valid),
        .w_last         (w_last),
        .w_strb         (w_strb),
        .w_data         (w_data),
        .b_ready        (b_ready),
        .b_valid        (b_valid),
        .b_resp         (b_resp),
        .cmd_aw_ready   (cmd_aw_ready),
        .cmd_aw_valid   (cmd_aw_valid),
        .cmd_aw_addr    (cmd_aw_addr),
        .cmd_aw_len     (cmd_aw_len),
        .cmd_w_ready    (cmd_w_ready),
        .cmd_w_valid    (cmd_w_valid),
        .cmd_w_strb     (cmd_w_strb),
        .tlp_d_ready    (tlp_d_ready),
        .tlp_d_valid    (tlp_d_valid),
        .tlp_d_data     (tlp_d_data),
        .tlp_d_axi_last (tlp_d_axi_last),
        .tlp_d_axi_ack  (tlp_d_axi_ack),
        .wr_busy        (wr_busy),
        .wr_disable     (wr_disable),
        .wr_flush       (wr_flush)
    );

    write_cmd_splitter #(
        .ADDR        (ADDR),
        .LEN         (LEN),
        .MAX_PAYLOAD (MAX_PAYLOAD)
    ) splitter_i (
        .clk          (clk),
        .rst          (rst),
        .cmd_aw_ready (cmd_aw_ready),
        .cmd_aw_valid (cmd_aw_valid),
        .cmd_aw_addr  (cmd_aw_addr),
        .cmd_aw_len   (cmd_aw_len),
        .cmd_w_ready  (cmd_w_ready),
        .cmd_w_valid  (cmd_w_valid),
        .cmd_w_strb   (cmd_w_strb),
        .req_ready    (req_ready),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .req_len      (req_len),
        .req_first_be (req_first_be),
        .req_last_be  (req_last_be)
    );

    tlp_write_framer #(
        .ADDR (ADDR)
    ) framer_i (
        .clk            (clk),
        .rst            (rst),
        .req_ready      (req_ready),
        .req_valid      (req_valid),
        .req_addr       (req_addr),
        .req_len        (req_len),
        .req_first_be   (req_first_be),
        .req_last_be    (req_last_be),
        .tlp_d_ready    (tlp_d_ready),
        .tlp_d_valid    (tlp_d_valid),
        .tlp_d_data     (tlp_d_data),
        .tlp_d_axi_last (tlp_d_axi_last),
        .tlp_d_axi_ack  (tlp_d_axi_ack),
        .tlp_ready      (tlp_ready),
        .tlp_valid      (tlp_valid),
        .tlp_data       (tlp_data),
        .tlp_sof        (tlp_sof),
        .tlp_eof        (tlp_eof)
    );

endmodule

/* hdl/tlp_write_framer.sv */
`timescale 1ns/10ps

module tlp_write_framer import pcie_wr_pkg::*; #(
    parameter int ADDR = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    output logic                 req_ready,
    input  logic                 req_valid,
    input  logic [ADDR-1:2]      req_addr,
    input  logic [tlp_len_w-1:0] req_len,
    input  logic [tlp_be_w-1:0]  req_first_be,
    input  logic [tlp_be_w-1:0]  req_last_be,
    output logic                 tlp_d_ready,
    input  logic                 tlp_d_valid,
    input  logic [31:0]          tlp_d_data,
    input  logic                 tlp_d_axi_last,
    output logic                 tlp_d_axi_ack,
    input  logic                 tlp_ready,
    output logic                 tlp_valid,
    output logic [31:0]          tlp_data,
    output logic                 tlp_sof,
    output logic                 tlp_eof
);

    localparam logic [1:0] S_HDR0 = 2'd0;
    localparam logic [1:0] S_HDR1 = 2'd1;
    localparam logic [1:0] S_PAY  = 2'd2;

    logic [1:0]           state;
    logic [tlp_len_w-1:0] remain;
    logic                 tlp_xfer;

    assign tlp_xfer = tlp_ready && tlp_valid;

    always_comb begin
        tlp_valid = 1'b0;
        tlp_data  = '0;
        case (state)
            S_HDR0: begin
                tlp_valid = req_valid;
                tlp_data  = {8'd0, req_last_be, req_first_be, 6'd0, req_len};
            end
            S_HDR1: begin
                tlp_valid = 1'b1;
                tlp_data  = 32'({req_addr, 2'b00});
            end
            S_PAY: begin
                tlp_valid = tlp_d_valid;
                tlp_data  = tlp_d_data;
            end
            default: begin
                tlp_valid = 1'b0;
            end
        endcase
    end

    assign tlp_sof       = (state == S_HDR0);
    assign tlp_eof       = (state == S_PAY) && (remain == tlp_len_w'(1));
    // Request is released once its address dword goes out
    assign req_ready     = (state == S_HDR1) && tlp_ready;
    assign tlp_d_ready   = (state == S_PAY) && tlp_ready;
    assign tlp_d_axi_ack = tlp_d_ready && tlp_d_valid && tlp_d_axi_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= S_HDR0;
            remain <= '0;
        end else if (tlp_xfer) begin
            case (state)
                S_HDR0: state <= S_HDR1;
                S_HDR1: begin
                    state  <= S_PAY;
                    remain <= req_len;
                end
                default: begin
                    remain <= remain - 1'b1;
                    if (remain == tlp_len_w'(1)) begin
                        state <= S_HDR0;
                    end
                end
            endcase
        end
    end

endmodule

/* hdl/write_cmd_splitter.sv */
`timescale 1ns/10ps

module write_cmd_splitter import pcie_wr_pkg::*; #(
    parameter int ADDR        = 32,
    parameter int LEN         = 4,
    parameter int MAX_PAYLOAD = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    output logic                 cmd_aw_ready,
    input  logic                 cmd_aw_valid,
    input  logic [ADDR-1:2]      cmd_aw_addr,
    input  logic [LEN-1:0]       cmd_aw_len,
    output logic                 cmd_w_ready,
    input  logic                 cmd_w_valid,
    input  logic [3:0]           cmd_w_strb,
    input  logic                 req_ready,
    output logic                 req_valid,
    output logic [ADDR-1:2]      req_addr,
    output logic [tlp_len_w-1:0] req_len,
    output logic [tlp_be_w-1:0]  req_first_be,
    output logic [tlp_be_w-1:0]  req_last_be
);

    localparam int MPB = clog2_f(MAX_PAYLOAD);
    // Wide enough for a whole burst or a whole piece
    localparam int CW  = (LEN > MPB) ? LEN + 1 : MPB + 1;

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_STRB = 2'd1;
    localparam logic [1:0] S_REQ  = 2'd2;

    logic [1:0]      state;
    logic [ADDR-1:2] cur_addr;
    logic [CW-1:0]   remain;
    logic [CW-1:0]   strb_cnt;
    logic [CW-1:0]   offset;
    logic [CW-1:0]   to_bound;
    logic [CW-1:0]   piece_len;

    // Dwords left before the next MAX_PAYLOAD boundary
    assign offset    = CW'(cur_addr & (ADDR-2)'(MAX_PAYLOAD - 1));
    assign to_bound  = CW'(MAX_PAYLOAD) - offset;
    assign piece_len = (remain < to_bound) ? remain : to_bound;

    assign cmd_aw_ready = (state == S_IDLE);
    assign cmd_w_ready  = (state == S_STRB);
    assign req_valid    = (state == S_REQ);
    assign req_addr     = cur_addr;
    assign req_len      = tlp_len_w'(piece_len);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            strb_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (cmd_aw_valid) begin
                        state <= S_STRB;
                    end
                end
                S_STRB: begin
                    // One strobe per dword of the piece
                    if (cmd_w_valid) begin
                        if (strb_cnt == piece_len - CW'(1)) begin
                            strb_cnt <= '0;
                            state    <= S_REQ;
                        end else begin
                            strb_cnt <= strb_cnt + CW'(1);
                        end
                    end
                end
                S_REQ: begin
                    if (req_ready) begin
                        state <= (remain == piece_len) ? S_IDLE : S_STRB;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_aw_ready && cmd_aw_valid) begin
            cur_addr <= cmd_aw_addr;
            remain   <= CW'(cmd_aw_len) + CW'(1);
        end
        if (req_valid && req_ready) begin
            cur_addr <= cur_addr + (ADDR-2)'(piece_len);
            remain   <= remain - piece_len;
        end
        // Last byte enables stay zero for a single-dword piece
        if (cmd_w_ready && cmd_w_valid) begin
            if (strb_cnt == '0) begin
                req_first_be <= cmd_w_strb;
                req_last_be  <= '0;
            end else begin
                req_last_be <= cmd_w_strb;
            end
        end
    end

endmodule

/* write_buffer/outbound_write_buffer.sv */
`timescale 1ns/10ps

module outbound_write_buffer import pcie_wr_pkg::*; #(
    parameter int ADDR = 32,
    parameter int LEN  = 4,
    parameter int MOT  = 16,
    parameter int BUFA = LEN + 1
) (
    input  logic            clk,
    input  logic            rst,
    output logic            aw_ready,
    input  logic            aw_valid,
    input  logic [ADDR-1:0] aw_addr,
    input  logic [LEN-1:0]  aw_len,
    output logic            w_ready,
    input  logic            w_valid,
    input  logic            w_last,
    input  logic [3:0]      w_strb,
    input  logic [31:0]     w_data,
    input  logic            b_ready,
    output logic            b_valid,
    output logic [1:0]      b_resp,
    input  logic            cmd_aw_ready,
    output logic            cmd_aw_valid,
    output logic [ADDR-1:2] cmd_aw_addr,
    output logic [LEN-1:0]  cmd_aw_len,
    input  logic            cmd_w_ready,
    output logic            cmd_w_valid,
    output logic [3:0]      cmd_w_strb,
    input  logic            tlp_d_ready,
    output logic            tlp_d_valid,
    output logic [31:0]     tlp_d_data,
    output logic            tlp_d_axi_last,
    input  logic            tlp_d_axi_ack,
    output logic            wr_busy,
    input  logic            wr_disable,
    input  logic            wr_flush
);

    localparam int MOTB = clog2_f(MOT);

    logic [MOTB:0] mot_cnt;
    logic          mot_zero;
    logic          mot_full;
    logic [MOTB:0] next_mot_cnt;
    logic          next_mot_zero;
    logic          next_mot_full;
    logic          aw_xfer;
    logic          w_xfer;
    logic          b_xfer;
    logic [BUFA:0] buf_free;
    logic [BUFA:0] next_buf_free;
    logic          aw_almost_full;
    logic [MOTB:0] w_cnt;
    logic          w_done;
    logic [MOTB:0] b_cnt;
    logic          b_cnt_zero;
    logic [MOTB:0] next_b_cnt;
    logic          next_b_cnt_zero;
    logic          b_inc;
    logic          b_dec;

    assign aw_xfer = aw_ready && aw_valid;
    assign w_xfer  = w_ready && w_valid;
    assign w_done  = w_xfer && w_last;
    assign b_xfer  = b_ready && b_valid;
    assign wr_busy = !mot_zero;

    // Outstanding bursts, from AW accept to B accept
    always_comb begin
        next_mot_cnt  = mot_cnt;
        next_mot_zero = mot_zero;
        next_mot_full = mot_full;
        if (aw_xfer && !b_xfer) begin
            next_mot_cnt  = mot_cnt + 1'b1;
            next_mot_zero = 1'b0;
            next_mot_full = (mot_cnt == (MOTB+1)'(MOT - 1));
        end
        if (!aw_xfer && b_xfer) begin
            next_mot_cnt  = mot_cnt - 1'b1;
            next_mot_zero = (mot_cnt == (MOTB+1)'(1));
            next_mot_full = 1'b0;
        end
    end

    // Words reserved per burst, returned as payload leaves
    always_comb begin
        next_buf_free = buf_free;
        if (aw_xfer) begin
            next_buf_free = next_buf_free - (BUFA+1)'(aw_len) - (BUFA+1)'(1);
        end
        if (tlp_d_ready && tlp_d_valid) begin
            next_buf_free = next_buf_free + (BUFA+1)'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mot_cnt  <= '0;
            mot_zero <= 1'b1;
            mot_full <= 1'b0;
            buf_free <= (BUFA+1)'(2**BUFA);
            aw_ready <= 1'b0;
        end else begin
            mot_cnt  <= next_mot_cnt;
            mot_zero <= next_mot_zero;
            mot_full <= next_mot_full;
            buf_free <= next_buf_free;
            // Room for a full-length burst is required
            aw_ready <= (|next_buf_free[BUFA:LEN]) && !next_mot_full &&
                        !aw_almost_full && !wr_disable;
        end
    end

    fifo_rvho #(
        .DATA        (ADDR - 2 + LEN),
        .ADDR        (2),
        .ALMOST_FULL (1)
    ) fifo_cmd_aw (
        .clk            (clk),
        .rst            (rst),
        .wr_push        (aw_xfer),
        .wr_data        ({aw_addr[ADDR-1:2], aw_len}),
        .wr_almost_full (aw_almost_full),
        .rd_ready       (cmd_aw_ready),
        .rd_valid       (cmd_aw_valid),
        .rd_data        ({cmd_aw_addr, cmd_aw_len})
    );

    // W only flows for commands already accepted
    always_ff @(posedge clk) begin
        if (rst) begin
            w_cnt   <= '0;
            w_ready <= 1'b0;
        end else begin
            if (aw_xfer && !w_done) begin
                w_cnt   <= w_cnt + 1'b1;
                w_ready <= 1'b1;
            end
            if (!aw_xfer && w_done) begin
                w_cnt   <= w_cnt - 1'b1;
                w_ready <= (w_cnt != (MOTB+1)'(1));
            end
        end
    end

    fifo_rvho #(
        .DATA        (4),
        .ADDR        (BUFA),
        .ALMOST_FULL (1)
    ) fifo_cmd_w (
        .clk            (clk),
        .rst            (rst),
        .wr_push        (w_xfer),
        .wr_data        (w_strb),
        .wr_almost_full (),
        .rd_ready       (cmd_w_ready),
        .rd_valid       (cmd_w_valid),
        .rd_data        (cmd_w_strb)
    );

    fifo_rvho #(
        .DATA        (33),
        .ADDR        (BUFA),
        .ALMOST_FULL (1)
    ) fifo_tlp_d (
        .clk            (clk),
        .rst            (rst),
        .wr_push        (w_xfer),
        .wr_data        ({w_last, w_data}),
        .wr_almost_full (),
        .rd_ready       (tlp_d_ready),
        .rd_valid       (tlp_d_valid),
        .rd_data        ({tlp_d_axi_last, tlp_d_data})
    );

    // Completed bursts waiting for a B response
    assign b_inc = tlp_d_axi_ack && !wr_flush;
    assign b_dec = b_xfer && !b_cnt_zero;

    always_comb begin
        next_b_cnt      = b_cnt;
        next_b_cnt_zero = b_cnt_zero;
        if (b_inc && !b_dec) begin
            next_b_cnt      = b_cnt + 1'b1;
            next_b_cnt_zero = 1'b0;
        end
        if (!b_inc && b_dec) begin
            next_b_cnt      = b_cnt - 1'b1;
            next_b_cnt_zero = (b_cnt == (MOTB+1)'(1));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            b_cnt      <= '0;
            b_cnt_zero <= 1'b1;
            b_valid    <= 1'b0;
            b_resp     <= axi_resp_okay;
        end else begin
            b_cnt      <= next_b_cnt;
            b_cnt_zero <= next_b_cnt_zero;
            if (b_ready || !b_valid) begin
                if (!next_b_cnt_zero) begin
                    b_valid <= 1'b1;
                    b_resp  <= axi_resp_okay;
                end else if (!next_mot_zero && wr_flush) begin
                    // Burst dropped by the flush
                    b_valid <= 1'b1;
                    b_resp  <= axi_resp_slverr;
                end else begin
                    b_valid <= 1'b0;
                    b_resp  <= axi_resp_okay;
                end
            end
        end
    end

endmodule

/* hdl/fifo_rvho.sv */
`timescale 1ns/10ps

module fifo_rvho #(
    parameter int DATA        = 8,
    parameter int ADDR        = 4,
    parameter int ALMOST_FULL = 1
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            wr_push,
    input  logic [DATA-1:0] wr_data,
    output logic            wr_almost_full,
    input  logic            rd_ready,
    output logic            rd_valid,
    output logic [DATA-1:0] rd_data
);

    logic [DATA-1:0] mem [2**ADDR];
    logic [ADDR-1:0] wr_ptr;
    logic [ADDR-1:0] rd_ptr;
    logic [ADDR:0]   count;
    logic            rd_pop;

    // Refill the output register when it is empty or being drained
    assign rd_pop = (count != '0) && (!rd_valid || rd_ready);

    // Free RAM entries at or below the threshold
    assign wr_almost_full = (count >= (ADDR+1)'(2**ADDR - ALMOST_FULL));

    always_ff @(posedge clk) begin
        if (wr_push) begin
            mem[wr_ptr] <= wr_data;
        end
        if (rd_pop) begin
            rd_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (wr_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (ADDR+1)'(wr_push) - (ADDR+1)'(rd_pop);
            if (rd_pop) begin
                rd_valid <= 1'b1;
            end else if (rd_ready) begin
                rd_valid <= 1'b0;
            end
        end
    end

endmodule

/* common/pcie_wr_pkg.sv */
package pcie_wr_pkg;

    // AXI write response codes
    localparam logic [1:0] axi_resp_okay   = 2'b00;
    // Write lost to a flush
    localparam logic [1:0] axi_resp_slverr = 2'b10;

    // TLP header field widths
    localparam int tlp_len_w = 10;
    localparam int tlp_be_w  = 4;

    // Ceiling of log2, sizes counters and FIFO pointers
    function automatic int clog2_f(input int value);
        int result;
        result = 0;
        while ((1 << result) < value) begin
            result = result + 1;
        end
        return result;
    endfunction

endpackage
